// File: Bender.yml
package:
  name: soc_fabric

sources:
  - files:
      - design/bus_pkg.sv
      - design/soc_map_pkg.sv
      - design/mem_bus_if.sv
      - design/reset_sync.sv
      - design/addr_decoder.sv
      - design/boot_rom.sv
      - design/sram.sv
      - design/clint.sv
      - design/soc_fabric.sv
  - target: simulation
    files:
      - sim/soc_fabric_properties.sv
      - sim/tb_soc_fabric.sv

// File: design/addr_decoder.sv
/*
 * Splits the requester bus over ROM, CLINT and DRAM by address.
 * Every request gets rvalid one cycle later, reads and writes alike.
 * Unmapped addresses give err with zero read data.
 */

module addr_decoder (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           req_i,
    input  logic           we_i,
    input  bus_pkg::addr_t addr_i,
    input  bus_pkg::be_t   be_i,
    input  bus_pkg::data_t wdata_i,
    output logic           rvalid_o,
    output bus_pkg::data_t rdata_o,
    output logic           err_o,
    mem_bus_if.initiator   rom_o,
    mem_bus_if.initiator   clint_o,
    mem_bus_if.initiator   dram_o
);

    soc_map_pkg::target_sel_t sel_d;
    soc_map_pkg::target_sel_t sel_q;
    bus_pkg::addr_t           offset;
    logic                     req_q;

    // --------------------------------------------------
    // Region match
    // --------------------------------------------------
    always_comb begin
        sel_d  = soc_map_pkg::NONE;
        offset = '0;
        if (addr_i >= soc_map_pkg::ROM_BASE &&
            addr_i < soc_map_pkg::ROM_BASE + soc_map_pkg::ROM_LENGTH) begin
            sel_d  = soc_map_pkg::ROM;
            offset = addr_i - soc_map_pkg::ROM_BASE;
        end else if (addr_i >= soc_map_pkg::CLINT_BASE &&
                     addr_i < soc_map_pkg::CLINT_BASE + soc_map_pkg::CLINT_LENGTH) begin
            sel_d  = soc_map_pkg::CLINT;
            offset = addr_i - soc_map_pkg::CLINT_BASE;
        end else if (addr_i >= soc_map_pkg::DRAM_BASE &&
                     addr_i < soc_map_pkg::DRAM_BASE + soc_map_pkg::DRAM_LENGTH) begin
            sel_d  = soc_map_pkg::DRAM;
            offset = addr_i - soc_map_pkg::DRAM_BASE;
        end
    end

    // Only the selected target sees the strobe
    assign rom_o.req   = req_i && (sel_d == soc_map_pkg::ROM);
    assign rom_o.we    = we_i;
    assign rom_o.addr  = offset;
    assign rom_o.be    = be_i;
    assign rom_o.wdata = wdata_i;

    assign clint_o.req   = req_i && (sel_d == soc_map_pkg::CLINT);
    assign clint_o.we    = we_i;
    assign clint_o.addr  = offset;
    assign clint_o.be    = be_i;
    assign clint_o.wdata = wdata_i;

    assign dram_o.req   = req_i && (sel_d == soc_map_pkg::DRAM);
    assign dram_o.we    = we_i;
    assign dram_o.addr  = offset;
    assign dram_o.be    = be_i;
    assign dram_o.wdata = wdata_i;

    // --------------------------------------------------
    // Response
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_q <= 1'b0;
            sel_q <= soc_map_pkg::NONE;
        end else begin
            req_q <= req_i;
            if (req_i) begin
                sel_q <= sel_d;
            end
        end
    end

    assign rvalid_o = req_q;
    assign err_o    = req_q && (sel_q == soc_map_pkg::NONE);

    always_comb begin
        case (sel_q)
            soc_map_pkg::ROM:   rdata_o = rom_o.rdata;
            soc_map_pkg::CLINT: rdata_o = clint_o.rdata;
            soc_map_pkg::DRAM:  rdata_o = dram_o.rdata;
            default:            rdata_o = '0;
        endcase
    end

endmodule

// File: design/boot_rom.sv
/*
 * Fixed boot image of 32 words, registered read.
 * Writes are accepted and dropped.
 */

module boot_rom (
    input  logic       clk_i,
    mem_bus_if.target  bus_i
);

    logic [$clog2(soc_map_pkg::ROM_WORDS)-1:0] word_idx;
    bus_pkg::data_t                            rom_word;
    bus_pkg::data_t                            rdata_q;

    assign word_idx = bus_i.addr[bus_pkg::ADDR_LSB +: $clog2(soc_map_pkg::ROM_WORDS)];

    always_comb begin
        case (word_idx)
            'd0:     rom_word = 64'h0000_0297_0010_0093;
            'd1:     rom_word = 64'h0002_8067_0000_0013;
            'd2:     rom_word = 64'h1234_5678_9ABC_DEF0;
            default: rom_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.req && !bus_i.we) begin
            rdata_q <= rom_word;
        end
    end

    assign bus_i.rdata = rdata_q;

endmodule

// File: design/bus_pkg.sv
/*
 * Widths and vector types of the requester bus.
 * One 64-bit word per request; addresses are byte addresses.
 * Sub-word accesses are expressed with byte enables only.
 */

package bus_pkg;

    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 64;
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

    // Address bits below one bus word
    localparam int unsigned ADDR_LSB = $clog2(BE_WIDTH);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BE_WIDTH-1:0]   be_t;

endpackage

// File: design/clint.sv
/*
 * Core-local interruptor for a single hart.
 * rtc_i must be slower than clk_i; mtime counts its rising edges.
 * mtime is read-only from the bus. Unknown offsets read zero.
 */

module clint (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       rtc_i,
    mem_bus_if.target  bus_i,
    output logic       timer_irq_o,
    output logic       ipi_o
);

    // Two sync stages plus one for the edge
    logic [2:0]     rtc_q;
    logic           rtc_rise;
    bus_pkg::addr_t reg_addr;
    bus_pkg::data_t mtime_q;
    bus_pkg::data_t mtimecmp_q;
    bus_pkg::data_t rdata_q;
    logic           msip_q;
    logic           irq_q;

    assign rtc_rise = rtc_q[1] && !rtc_q[2];
    assign reg_addr = {bus_i.addr[bus_pkg::ADDR_WIDTH-1:bus_pkg::ADDR_LSB],
                       {bus_pkg::ADDR_LSB{1'b0}}};

    // --------------------------------------------------
    // Timer and interrupt registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rtc_q      <= '0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
            irq_q      <= 1'b0;
        end else begin
            rtc_q <= {rtc_q[1:0], rtc_i};
            irq_q <= (mtime_q >= mtimecmp_q);
            if (rtc_rise) begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (bus_i.req && bus_i.we) begin
                if (reg_addr == soc_map_pkg::MSIP_OFFSET && bus_i.be[0]) begin
                    msip_q <= bus_i.wdata[0];
                end
                if (reg_addr == soc_map_pkg::MTIMECMP_OFFSET) begin
                    for (int b = 0; b < bus_pkg::BE_WIDTH; b++) begin
                        if (bus_i.be[b]) begin
                            mtimecmp_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // Read path
    always_ff @(posedge clk_i) begin
        if (bus_i.req && !bus_i.we) begin
            case (reg_addr)
                soc_map_pkg::MSIP_OFFSET:     rdata_q <= {{63{1'b0}}, msip_q};
                soc_map_pkg::MTIMECMP_OFFSET: rdata_q <= mtimecmp_q;
                soc_map_pkg::MTIME_OFFSET:    rdata_q <= mtime_q;
                default:                      rdata_q <= '0;
            endcase
        end
    end

    assign bus_i.rdata = rdata_q;
    assign timer_irq_o = irq_q;
    assign ipi_o       = msip_q;

endmodule

// File: design/mem_bus_if.sv
/*
 * One request and its read data between the decoder and a target.
 * req is a single-cycle strobe, there is no back-pressure.
 * addr is the offset inside the target's region.
 * Read data is expected one cycle after req.
 */

interface mem_bus_if;

    logic           req;
    logic           we;
    bus_pkg::addr_t addr;
    bus_pkg::be_t   be;
    bus_pkg::data_t wdata;
    bus_pkg::data_t rdata;

    modport initiator (output req, we, addr, be, wdata, input rdata);

    modport target (input req, we, addr, be, wdata, output rdata);

endinterface

// File: design/reset_sync.sv
/*
 * System reset from power-on reset and debug ndmreset.
 * Asserts as soon as either source is high, releases on the clock
 * two cycles after both have dropped. Both sources are expected
 * to be synchronous to clk_i.
 */

module reset_sync (
    input  logic clk_i,
    input  logic rst_i,
    input  logic ndmreset_i,
    output logic sys_rst_o
);

    logic [1:0] rst_q;

    always_ff @(posedge clk_i) begin
        if (rst_i || ndmreset_i) begin
            rst_q <= 2'b11;
        end else begin
            rst_q <= {rst_q[0], 1'b0};
        end
    end

    assign sys_rst_o = rst_q[1] || rst_i || ndmreset_i;

endmodule

// File: design/soc_fabric.sv
/*
 * Memory side of the single-hart test harness.
 * One requester, no back-pressure, response one cycle after each req.
 * ndmreset resets everything but the SRAM contents.
 */

module soc_fabric (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           rtc_i,
    input  logic           ndmreset_i,
    input  logic           req_i,
    input  logic           we_i,
    input  bus_pkg::addr_t addr_i,
    input  bus_pkg::be_t   be_i,
    input  bus_pkg::data_t wdata_i,
    output logic           rvalid_o,
    output bus_pkg::data_t rdata_o,
    output logic           err_o,
    output logic           timer_irq_o,
    output logic           ipi_o
);

    logic sys_rst;

    mem_bus_if rom_bus ();
    mem_bus_if clint_bus ();
    mem_bus_if dram_bus ();

    reset_sync i_reset_sync (
        .clk_i      ( clk_i      ),
        .rst_i      ( rst_i      ),
        .ndmreset_i ( ndmreset_i ),
        .sys_rst_o  ( sys_rst    )
    );

    // --------------------------------------------------
    // Decoder
    // --------------------------------------------------
    addr_decoder i_addr_decoder (
        .clk_i    ( clk_i     ),
        .rst_i    ( sys_rst   ),
        .req_i    ( req_i     ),
        .we_i     ( we_i      ),
        .addr_i   ( addr_i    ),
        .be_i     ( be_i      ),
        .wdata_i  ( wdata_i   ),
        .rvalid_o ( rvalid_o  ),
        .rdata_o  ( rdata_o   ),
        .err_o    ( err_o     ),
        .rom_o    ( rom_bus   ),
        .clint_o  ( clint_bus ),
        .dram_o   ( dram_bus  )
    );

    // --------------------------------------------------
    // Targets
    // --------------------------------------------------
    boot_rom i_boot_rom (
        .clk_i ( clk_i   ),
        .bus_i ( rom_bus )
    );

    // Kept out of reset so ndmreset leaves memory alone
    sram #(
        .NUM_WORDS ( soc_map_pkg::DRAM_WORDS )
    ) i_sram (
        .clk_i ( clk_i    ),
        .bus_i ( dram_bus )
    );

    clint i_clint (
        .clk_i       ( clk_i       ),
        .rst_i       ( sys_rst     ),
        .rtc_i       ( rtc_i       ),
        .bus_i       ( clint_bus   ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

endmodule

// File: design/soc_map_pkg.sv
/*
 * Memory map of the harness and CLINT register offsets.
 * Regions must not overlap; lengths are multiples of one bus word.
 * Anything outside the three regions is answered with an error.
 */

package soc_map_pkg;

    // Boot ROM, 32 words
    localparam bus_pkg::addr_t ROM_BASE   = 32'h0001_0000;
    localparam bus_pkg::addr_t ROM_LENGTH = 32'h0000_0100;

    localparam bus_pkg::addr_t CLINT_BASE   = 32'h0200_0000;
    localparam bus_pkg::addr_t CLINT_LENGTH = 32'h0000_C000;

    // Main memory, 1024 words
    localparam bus_pkg::addr_t DRAM_BASE   = 32'h8000_0000;
    localparam bus_pkg::addr_t DRAM_LENGTH = 32'h0000_2000;

    localparam int unsigned ROM_WORDS  = ROM_LENGTH >> bus_pkg::ADDR_LSB;
    localparam int unsigned DRAM_WORDS = DRAM_LENGTH >> bus_pkg::ADDR_LSB;

    // CLINT registers, relative to CLINT_BASE
    localparam bus_pkg::addr_t MSIP_OFFSET     = 32'h0000_0000;
    localparam bus_pkg::addr_t MTIMECMP_OFFSET = 32'h0000_4000;
    localparam bus_pkg::addr_t MTIME_OFFSET    = 32'h0000_BFF8;

    typedef enum logic [1:0] {
        ROM,
        CLINT,
        DRAM,
        NONE
    } target_sel_t;

endpackage

// File: design/sram.sv
/*
 * Single-port main memory with byte enables and registered read.
 * No reset, contents are undefined until written and survive ndmreset.
 * NUM_WORDS has to match the DRAM region of the memory map.
 */

module sram #(
    parameter int unsigned NUM_WORDS = 1024
) (
    input  logic       clk_i,
    mem_bus_if.target  bus_i
);

    bus_pkg::data_t                 mem_q [NUM_WORDS];
    bus_pkg::data_t                 rdata_q;
    logic [$clog2(NUM_WORDS)-1:0]   word_idx;

    assign word_idx = bus_i.addr[bus_pkg::ADDR_LSB +: $clog2(NUM_WORDS)];

    always_ff @(posedge clk_i) begin
        if (bus_i.req) begin
            if (bus_i.we) begin
                // Byte lanes without enable keep their old value
                for (int b = 0; b < bus_pkg::BE_WIDTH; b++) begin
                    if (bus_i.be[b]) begin
                        mem_q[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[word_idx];
            end
        end
    end

    assign bus_i.rdata = rdata_q;

endmodule

// File: filelist.f
design/bus_pkg.sv
design/soc_map_pkg.sv
design/mem_bus_if.sv
design/reset_sync.sv
design/addr_decoder.sv
design/boot_rom.sv
design/sram.sv
design/clint.sv
design/soc_fabric.sv
sim/soc_fabric_properties.sv
sim/tb_soc_fabric.sv

// File: sim/soc_fabric_properties.sv
/*
 * Concurrent checks on the soc_fabric ports, bound into soc_fabric.
 * Protocol checks pause while rst_i is high.
 * Requests are expected to stay low while ndmreset is active.
 */

module soc_fabric_properties (
    input logic           clk_i,
    input logic           rst_i,
    input logic           req_i,
    input bus_pkg::addr_t addr_i,
    input logic           rvalid_i,
    input logic           err_i,
    input logic           timer_irq_i,
    input logic           ipi_i
);

    soc_map_pkg::target_sel_t sel;

    // Unsigned wrap makes one compare per region enough
    function automatic soc_map_pkg::target_sel_t region_of(input bus_pkg::addr_t addr);
        region_of = soc_map_pkg::NONE;
        if (addr - soc_map_pkg::ROM_BASE < soc_map_pkg::ROM_LENGTH) begin
            region_of = soc_map_pkg::ROM;
        end else if (addr - soc_map_pkg::CLINT_BASE < soc_map_pkg::CLINT_LENGTH) begin
            region_of = soc_map_pkg::CLINT;
        end else if (addr - soc_map_pkg::DRAM_BASE < soc_map_pkg::DRAM_LENGTH) begin
            region_of = soc_map_pkg::DRAM;
        end
    endfunction

    assign sel = region_of(addr_i);

    // --------------------------------------------------
    // Response timing
    // --------------------------------------------------
    rvalid_follows_req: assert property (
        @(posedge clk_i) disable iff (rst_i) rvalid_i == $past(req_i)
    ) else $error("rvalid_o does not follow req_i by one cycle");

    err_only_with_rvalid: assert property (
        @(posedge clk_i) err_i |-> rvalid_i
    ) else $error("err_o high without rvalid_o");

    err_for_unmapped: assert property (
        @(posedge clk_i) disable iff (rst_i)
        req_i |=> err_i == ($past(sel) == soc_map_pkg::NONE)
    ) else $error("err_o does not match the memory map");

    // Second reset cycle onwards, registers have settled
    outputs_low_in_reset: assert property (
        @(posedge clk_i) rst_i && $past(rst_i) |-> !rvalid_i && !err_i && !timer_irq_i && !ipi_i
    ) else $error("control outputs not low during reset");

endmodule

// File: sim/soc_fabric_tests.txt
# op addr be wdata expected_rdata expected_err, all hex, one access per line
# rtc: wdata is the pulse count; waitirq: expected_rdata bit 1 is ipi_o, bit 0 timer_irq_o
read     00010000 00 0                0000029700100093 0
read     00010010 00 0                123456789abcdef0 0
read     00010028 00 0                0                0
write    00010010 ff ffffffffffffffff 0                0
read     00010010 00 0                123456789abcdef0 0
write    80000100 ff 1122334455667788 0                0
write    80000100 0f aaaaaaaaaaaaaaaa 0                0
write    80000108 ff 0102030405060708 0                0
write    80000108 c3 f0f0f0f0f0f0f0f0 0                0
read     80000100 00 0                11223344aaaaaaaa 0
read     80000108 00 0                f0f003040506f0f0 0
read     40000000 00 0                0                1
write    40000000 ff 5555             0                1
read     00010100 00 0                0                1
read     0200bff8 00 0                0                0
write    02004000 ff 5                0                0
read     02004000 00 0                5                0
rtc      00000000 00 5                0                0
waitirq  00000000 00 0                1                0
read     0200bff8 00 0                5                0
write    02004000 ff ffffffffffffffff 0                0
waitirq  00000000 00 0                0                0
write    02000000 01 1                0                0
waitirq  00000000 00 0                2                0
write    02000000 01 0                0                0
waitirq  00000000 00 0                0                0
write    02000000 01 1                0                0
waitirq  00000000 00 0                2                0
ndmreset 00000000 00 0                0                0
read     02000000 00 0                0                0
read     02004000 00 0                ffffffffffffffff 0
read     0200bff8 00 0                0                0
waitirq  00000000 00 0                0                0
read     80000100 00 0                11223344aaaaaaaa 0

// File: sim/tb_soc_fabric.sv
/*
 * Testbench for soc_fabric, run from the project root.
 * Vectors come from sim/soc_fabric_tests.txt, one access per line.
 * Consecutive bus lines go out in consecutive cycles.
 * Read data is checked on reads and on error responses only.
 */

module tb_soc_fabric;

    localparam int unsigned IRQ_TIMEOUT = 200;
    localparam int unsigned RTC_HALF    = 3;

    logic           clk_i;
    logic           rst_i;
    logic           rtc_i;
    logic           ndmreset_i;
    logic           req_i;
    logic           we_i;
    bus_pkg::addr_t addr_i;
    bus_pkg::be_t   be_i;
    bus_pkg::data_t wdata_i;
    logic           rvalid_o;
    bus_pkg::data_t rdata_o;
    logic           err_o;
    logic           timer_irq_o;
    logic           ipi_o;
    int unsigned    errors;

    soc_fabric soc_fabric_inst (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .rtc_i       ( rtc_i       ),
        .ndmreset_i  ( ndmreset_i  ),
        .req_i       ( req_i       ),
        .we_i        ( we_i        ),
        .addr_i      ( addr_i      ),
        .be_i        ( be_i        ),
        .wdata_i     ( wdata_i     ),
        .rvalid_o    ( rvalid_o    ),
        .rdata_o     ( rdata_o     ),
        .err_o       ( err_o       ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

    bind soc_fabric soc_fabric_properties soc_fabric_properties_inst (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .req_i       ( req_i       ),
        .addr_i      ( addr_i      ),
        .rvalid_i    ( rvalid_o    ),
        .err_i       ( err_o       ),
        .timer_irq_i ( timer_irq_o ),
        .ipi_i       ( ipi_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // --------------------------------------------------
    // Bus access and response check
    // --------------------------------------------------
    task automatic issue_request(input logic we, input bus_pkg::addr_t addr,
                                 input bus_pkg::be_t be, input bus_pkg::data_t wdata,
                                 input bus_pkg::data_t exp_rdata, input logic exp_err);
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        be_i    = be;
        wdata_i = wdata;
        next_cycle();
        req_i = 1'b0;
        we_i  = 1'b0;
        assert (rvalid_o === 1'b1) else begin
            $display("no response one cycle after the request to %h", addr);
            errors++;
        end
        assert (err_o === exp_err) else begin
            $display("Error: err_o = %h, expected %h", err_o, exp_err);
            errors++;
        end
        if (!we || exp_err) begin
            assert (rdata_o === exp_rdata) else begin
                $display("Error: rdata_o = %h, expected %h", rdata_o, exp_rdata);
                errors++;
            end
        end
    endtask

    task automatic pulse_rtc(input int unsigned count);
        repeat (count) begin
            rtc_i = 1'b1;
            repeat (RTC_HALF) next_cycle();
            rtc_i = 1'b0;
            repeat (RTC_HALF) next_cycle();
        end
    endtask

    task automatic pulse_ndmreset();
        // Move mtimecmp off its reset value so the reset shows in a read
        issue_request(1'b1, soc_map_pkg::CLINT_BASE + soc_map_pkg::MTIMECMP_OFFSET, '1,
                      64'h0000_0001_0000_0000, '0, 1'b0);
        ndmreset_i = 1'b1;
        repeat (2) next_cycle();
        ndmreset_i = 1'b0;
        // System reset lasts two more cycles
        repeat (3) next_cycle();
    endtask

    task automatic wait_for_irq(input logic [1:0] expected);
        int unsigned cycles;
        cycles = 0;
        while ({ipi_o, timer_irq_o} !== expected && cycles < IRQ_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        assert (cycles < IRQ_TIMEOUT) else begin
            $display("timed out waiting for ipi_o and timer_irq_o to reach %b", expected);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int               fd;
        int               n;
        int unsigned      tests;
        int unsigned      passed;
        int unsigned      errors_before;
        logic [8*128-1:0] line_buf;
        logic [8*8-1:0]   op;
        bus_pkg::addr_t   addr;
        bus_pkg::be_t     be;
        bus_pkg::data_t   wdata;
        bus_pkg::data_t   exp_rdata;
        logic             exp_err;

        errors     = 0;
        tests      = 0;
        passed     = 0;
        rst_i      = 1'b1;
        rtc_i      = 1'b0;
        ndmreset_i = 1'b0;
        req_i      = 1'b0;
        we_i       = 1'b0;
        addr_i     = '0;
        be_i       = '0;
        wdata_i    = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        repeat (3) next_cycle();
        assert ({rvalid_o, err_o, timer_irq_o, ipi_o} === 4'b0000) else begin
            $display("control outputs not low after reset");
            errors++;
        end

        fd = $fopen("sim/soc_fabric_tests.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open the test vector file");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            n = $sscanf(line_buf, "%s %h %h %h %h %h", op, addr, be, wdata, exp_rdata, exp_err);
            // Comment and blank lines do not give six fields
            if (n == 6) begin
                errors_before = errors;
                tests++;
                case (op)
                    "read":     issue_request(1'b0, addr, be, wdata, exp_rdata, exp_err);
                    "write":    issue_request(1'b1, addr, be, wdata, exp_rdata, exp_err);
                    "rtc":      pulse_rtc(int'(wdata[15:0]));
                    "ndmreset": pulse_ndmreset();
                    "waitirq":  wait_for_irq(exp_rdata[1:0]);
                    default: begin
                        $display("unknown opcode %0s in the test vector file", op);
                        errors++;
                    end
                endcase
                if (errors == errors_before) begin
                    passed++;
                end
                $display("test %0d %0s %h: %0s", tests, op, addr,
                         (errors == errors_before) ? "passed" : "mismatch");
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d tests, %0d passed, %0d check errors", tests, passed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
